//--- ddr3_ctrl_top.f
verilog/ddr3_pkg.sv
verilog/ddr3_cmd_seq.sv
verilog/ddr3_wr_fmt.sv
verilog/ddr3_dq_lane.sv
verilog/ddr3_rd_gather.sv
verilog/ddr3_phy.sv
verilog/ddr3_ctrl_top.sv
test/ddr3_mem_model.sv
test/ddr3_ctrl_tb.sv

//--- test/ddr3_ctrl_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ddr3_ctrl_tb;

  import ddr3_pkg::*;

  localparam int CLK_HALF_NS  = 20;
  localparam int NUM_ACCESSES = 231;
  localparam int ACK_LIMIT    = 40;
  localparam int WATCHDOG_NS  = NUM_ACCESSES * 40 * 2 * CLK_HALF_NS + 20000;

  logic                      clock;
  logic                      reset;
  logic                      host_req;
  logic                      host_we;
  logic [HOST_ADDR_BITS-1:0] host_addr;
  logic [WORD_WIDTH-1:0]     host_wdata;
  logic [WORD_WIDTH/8-1:0]   host_wmask;
  logic                      host_ack;
  logic [WORD_WIDTH-1:0]     host_rdata;
  logic                      ddr_ck_p;
  logic                      ddr_ck_n;
  logic                      ddr_cke;
  logic                      ddr_rst_n;
  logic                      ddr_cs_n;
  logic                      ddr_ras_n;
  logic                      ddr_cas_n;
  logic                      ddr_we_n;
  logic [BANK_BITS-1:0]      ddr_ba;
  logic [ADDR_BITS-1:0]      ddr_a;
  logic [DQ_WIDTH/8-1:0]     ddr_dm;
  wire  [DQ_WIDTH/8-1:0]     ddr_dqs_p;
  wire  [DQ_WIDTH/8-1:0]     ddr_dqs_n;
  wire  [DQ_WIDTH-1:0]       ddr_dq;
  logic                      mem_err;

  logic [15:0]           lfsr_q;
  logic [WORD_WIDTH-1:0] ref_mem [0:(1 << HOST_ADDR_BITS)-1];
  int                    checks;
  int                    errors;
  bit                    stalled;

  ddr3_ctrl_top #(.DQ_WIDTH(DQ_WIDTH), .PREFETCH(1'b1)) u_ddr3_ctrl_top (
    .clock        (clock),
    .reset        (reset),
    .host_req_i   (host_req),
    .host_we_i    (host_we),
    .host_addr_i  (host_addr),
    .host_wdata_i (host_wdata),
    .host_wmask_i (host_wmask),
    .host_ack_o   (host_ack),
    .host_rdata_o (host_rdata),
    .ddr_ck_p_o   (ddr_ck_p),
    .ddr_ck_n_o   (ddr_ck_n),
    .ddr_cke_o    (ddr_cke),
    .ddr_rst_n_o  (ddr_rst_n),
    .ddr_cs_n_o   (ddr_cs_n),
    .ddr_ras_n_o  (ddr_ras_n),
    .ddr_cas_n_o  (ddr_cas_n),
    .ddr_we_n_o   (ddr_we_n),
    .ddr_ba_o     (ddr_ba),
    .ddr_a_o      (ddr_a),
    .ddr_dm_o     (ddr_dm),
    .ddr_dqs_p_io (ddr_dqs_p),
    .ddr_dqs_n_io (ddr_dqs_n),
    .ddr_dq_io    (ddr_dq)
  );

  ddr3_mem_model #(.QUARTER_NS(CLK_HALF_NS / 2)) u_mem_model (
    .ck_i           (ddr_ck_p),
    .cke_i          (ddr_cke),
    .rst_n_i        (ddr_rst_n),
    .cs_n_i         (ddr_cs_n),
    .ras_n_i        (ddr_ras_n),
    .cas_n_i        (ddr_cas_n),
    .we_n_i         (ddr_we_n),
    .ba_i           (ddr_ba),
    .a_i            (ddr_a),
    .dm_i           (ddr_dm),
    .dq_io          (ddr_dq),
    .protocol_err_o (mem_err)
  );

  always #(CLK_HALF_NS) clock = ~clock;

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [WORD_WIDTH-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[WORD_WIDTH-2:0], lfsr_q[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [WORD_WIDTH-1:0] got,
                             input logic [WORD_WIDTH-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  // Mask bit set blocks that byte
  task automatic apply_write(input logic [HOST_ADDR_BITS-1:0] addr,
                             input logic [WORD_WIDTH-1:0] wdata,
                             input logic [WORD_WIDTH/8-1:0] wmask);
    for (int j = 0; j < WORD_WIDTH / 8; j++) begin
      if (!wmask[j]) begin
        ref_mem[addr][8*j +: 8] = wdata[8*j +: 8];
      end
    end
  endtask

  // One four-phase access, with req held one cycle past ack
  task automatic run_access(input logic we, input logic [HOST_ADDR_BITS-1:0] addr,
                            input logic [WORD_WIDTH-1:0] wdata,
                            input logic [WORD_WIDTH/8-1:0] wmask);
    int waited;
    if (stalled) begin
      return;
    end
    @(negedge clock);
    check_value("host_ack_o", host_ack, 1'b0);
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    host_wmask = wmask;
    host_req   = 1'b1;
    waited     = 0;
    while (!host_ack && waited < ACK_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    assert (host_ack) else begin
      $display("No ack within %0d cycles for address %h at %0t ns", ACK_LIMIT, addr, $time);
      errors++;
      stalled = 1'b1;
    end
    if (stalled) begin
      return;
    end
    @(negedge clock);
    check_value("host_ack_o", host_ack, 1'b1);
    if (we) begin
      apply_write(addr, wdata, wmask);
    end else begin
      check_value("host_rdata_o", host_rdata, ref_mem[addr]);
    end
    host_req = 1'b0;
    @(negedge clock);
    check_value("host_ack_o", host_ack, 1'b0);
    // Every bank must be activated before use and precharged before the next row
    check_value("protocol_err_o", mem_err, 1'b0);
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    $display("test %0d %s: %0d errors", num, name, errors - errs_before);
  endtask

  task automatic check_pins_idle(input logic up);
    check_value("host_ack_o", host_ack, 1'b0);
    check_value("ddr_cke_o", ddr_cke, up);
    check_value("ddr_rst_n_o", ddr_rst_n, up);
    check_value("ddr_cs_n_o", ddr_cs_n, 1'b1);
    check_value("ddr_ras_n_o", ddr_ras_n, 1'b1);
    check_value("ddr_cas_n_o", ddr_cas_n, 1'b1);
    check_value("ddr_we_n_o", ddr_we_n, 1'b1);
    check_value("ddr_dq_io", ddr_dq, {DQ_WIDTH{1'bz}});
    check_value("ddr_dqs_p_io", ddr_dqs_p, {(DQ_WIDTH/8){1'bz}});
    check_value("ddr_dqs_n_io", ddr_dqs_n, {(DQ_WIDTH/8){1'bz}});
  endtask

  initial begin
    logic [WORD_WIDTH-1:0] rnd_we;
    logic [WORD_WIDTH-1:0] rnd_addr;
    logic [WORD_WIDTH-1:0] rnd_data;
    logic [WORD_WIDTH-1:0] rnd_mask;
    logic [HOST_ADDR_BITS-1:0] addr;
    int errs_before;
    clock      = 1'b0;
    reset      = 1'b1;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    host_wmask = '0;
    lfsr_q     = 16'd20441;
    checks     = 0;
    errors     = 0;
    stalled    = 1'b0;
    for (int i = 0; i < (1 << HOST_ADDR_BITS); i++) begin
      ref_mem[i] = '0;
    end

    errs_before = errors;
    repeat (3) @(negedge clock);
    check_pins_idle(1'b0);
    reset = 1'b0;
    repeat (3) @(negedge clock);
    check_pins_idle(1'b1);
    // Differential clock pins, sampled in the middle of each half
    @(posedge clock);
    #(CLK_HALF_NS / 2);
    check_value("ddr_ck_p_o", ddr_ck_p, 1'b1);
    check_value("ddr_ck_n_o", ddr_ck_n, 1'b0);
    @(negedge clock);
    #(CLK_HALF_NS / 2);
    check_value("ddr_ck_p_o", ddr_ck_p, 1'b0);
    check_value("ddr_ck_n_o", ddr_ck_n, 1'b1);
    report_test(1, "reset state", errs_before);

    errs_before = errors;
    draw_bits(WORD_WIDTH, rnd_data);
    run_access(1'b1, 10'h0a5, rnd_data, '0);
    run_access(1'b0, 10'h0a5, '0, '0);
    report_test(2, "write then read", errs_before);

    errs_before = errors;
    for (int i = 0; i < 4; i++) begin
      addr = 10'h1c0 + 10'(i);
      draw_bits(WORD_WIDTH, rnd_data);
      run_access(1'b1, addr, rnd_data, '0);
      draw_bits(WORD_WIDTH, rnd_data);
      draw_bits(WORD_WIDTH / 8, rnd_mask);
      run_access(1'b1, addr, rnd_data, rnd_mask[WORD_WIDTH/8-1:0]);
      run_access(1'b0, addr, '0, '0);
    end
    report_test(3, "masked writes", errs_before);

    errs_before = errors;
    run_access(1'b0, 10'h3ff, '0, '0);
    report_test(4, "unwritten read", errs_before);

    errs_before = errors;
    for (int n = 0; n < 200; n++) begin
      draw_bits(1, rnd_we);
      draw_bits(HOST_ADDR_BITS, rnd_addr);
      draw_bits(WORD_WIDTH, rnd_data);
      draw_bits(WORD_WIDTH / 8, rnd_mask);
      run_access(rnd_we[0], rnd_addr[HOST_ADDR_BITS-1:0], rnd_data,
                 rnd_mask[WORD_WIDTH/8-1:0]);
    end
    report_test(5, "random traffic", errs_before);

    // Bank 5, column block 2, rows 0 to 7
    errs_before = errors;
    for (int r = 0; r < 8; r++) begin
      draw_bits(WORD_WIDTH, rnd_data);
      run_access(1'b1, {3'd5, 4'(r), 3'd2}, rnd_data, '0);
    end
    for (int r = 7; r >= 0; r--) begin
      run_access(1'b0, {3'd5, 4'(r), 3'd2}, '0, '0);
    end
    report_test(6, "row changes in one bank", errs_before);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before all accesses finished", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/ddr3_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module ddr3_mem_model #(
  parameter int QUARTER_NS = 10
) (
  input  wire                            ck_i,
  input  wire                            cke_i,
  input  wire                            rst_n_i,
  input  wire                            cs_n_i,
  input  wire                            ras_n_i,
  input  wire                            cas_n_i,
  input  wire                            we_n_i,
  input  wire [ddr3_pkg::BANK_BITS-1:0]  ba_i,
  input  wire [ddr3_pkg::ADDR_BITS-1:0]  a_i,
  input  wire [ddr3_pkg::DQ_WIDTH/8-1:0] dm_i,
  inout  wire [ddr3_pkg::DQ_WIDTH-1:0]   dq_io,
  output logic                           protocol_err_o
);

  import ddr3_pkg::*;

  ddr3_cmd_u             cmd;
  logic [3:0]            open_row [0:7];
  logic [7:0]            bank_open;
  // One 16-bit cell per {bank, row, column}
  logic [DQ_WIDTH-1:0]   mem [0:8191];
  logic [DQ_WIDTH-1:0]   dq_out;
  logic                  dq_oe;

  assign cmd   = {cs_n_i, ras_n_i, cas_n_i, we_n_i};
  assign dq_io = dq_oe ? dq_out : 'z;

  initial begin
    dq_oe          = 1'b0;
    dq_out         = '0;
    bank_open      = '0;
    protocol_err_o = 1'b0;
    for (int i = 0; i < 8192; i++) begin
      mem[i] = '0;
    end
    for (int i = 0; i < 8; i++) begin
      open_row[i] = '0;
    end
  end

  function automatic int cell_index(logic [2:0] bank, logic [3:0] row, logic [5:0] col);
    return int'({bank, row, col});
  endfunction

  // Waits for the edge of transfer k, then a quarter period into that half
  task automatic next_transfer(input int k);
    if (k % 2 == 1) begin
      @(negedge ck_i);
    end else if (k > 0) begin
      @(posedge ck_i);
    end
    #(QUARTER_NS);
  endtask

  task automatic write_burst(input logic [2:0] bank, input logic [3:0] row,
                             input logic [5:0] col);
    int idx;
    int k;
    int b;
    repeat (WRITE_LAT) @(posedge ck_i);
    for (k = 0; k < 8; k++) begin
      next_transfer(k);
      idx = cell_index(bank, row, col + 6'(k));
      for (b = 0; b < DQ_WIDTH / 8; b++) begin
        // DM high keeps the stored byte
        if (!dm_i[b]) begin
          mem[idx][8*b +: 8] = dq_io[8*b +: 8];
        end
      end
    end
  endtask

  task automatic read_burst(input logic [2:0] bank, input logic [3:0] row,
                            input logic [5:0] col);
    int k;
    repeat (READ_LAT) @(posedge ck_i);
    for (k = 0; k < 8; k++) begin
      next_transfer(k);
      dq_out = mem[cell_index(bank, row, col + 6'(k))];
      dq_oe  = 1'b1;
    end
    @(posedge ck_i);
    #(QUARTER_NS);
    dq_oe = 1'b0;
  endtask

  // Command pins are stable in the low half of the clock
  always @(negedge ck_i) begin
    if (cke_i && rst_n_i) begin
      if ((cmd.code == CMD_READ || cmd.code == CMD_WRITE) && !bank_open[ba_i]) begin
        $display("Memory model: read or write to closed bank %0d at %0t ns", ba_i, $time);
        protocol_err_o <= 1'b1;
      end
      case (cmd.code)
        CMD_ACTIVATE: begin
          if (bank_open[ba_i]) begin
            $display("Memory model: ACTIVATE to bank %0d while a row is open at %0t ns",
                     ba_i, $time);
            protocol_err_o <= 1'b1;
          end
          open_row[ba_i]  <= a_i[3:0];
          bank_open[ba_i] <= 1'b1;
        end
        CMD_WRITE: begin
          fork
            write_burst(ba_i, open_row[ba_i], a_i[5:0]);
          join_none
        end
        CMD_READ: begin
          fork
            read_burst(ba_i, open_row[ba_i], a_i[5:0]);
          join_none
        end
        CMD_PRECHARGE: begin
          // A10 high closes every bank
          if (a_i[10]) begin
            bank_open <= '0;
          end else begin
            bank_open[ba_i] <= 1'b0;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/ddr3_cmd_seq.sv
`timescale 1ns/100ps
`default_nettype none

module ddr3_cmd_seq #(
  parameter bit PREFETCH = 1'b0
) (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 host_req_i,
  input  logic                                 host_we_i,
  input  logic [ddr3_pkg::HOST_ADDR_BITS-1:0]  host_addr_i,
  output logic                                 host_ack_o,
  output ddr3_pkg::ddr3_cmd_u                  dfi_cmd_o,
  output logic [ddr3_pkg::BANK_BITS-1:0]       dfi_bank_o,
  output logic [ddr3_pkg::ADDR_BITS-1:0]       dfi_addr_o,
  output logic                                 dfi_cke_o,
  output logic                                 dfi_rst_n_o,
  output logic                                 dfi_wstb_o,
  output logic                                 dfi_wren_o,
  output logic                                 dfi_rden_o,
  output logic [1:0]                           beat_sel_o,
  input  logic                                 rd_valid_i,
  input  logic                                 rd_last_i
);

  import ddr3_pkg::*;

  localparam logic [2:0] S_IDLE = 3'd0;
  localparam logic [2:0] S_ACT  = 3'd1;
  localparam logic [2:0] S_RCD  = 3'd2;
  localparam logic [2:0] S_RW   = 3'd3;
  localparam logic [2:0] S_DATA = 3'd4;
  localparam logic [2:0] S_PRE  = 3'd5;
  localparam logic [2:0] S_RP   = 3'd6;
  localparam logic [2:0] S_ACK  = 3'd7;

  // Offsets from the DFI WRITE/READ cycle; the pins lag DFI by one cycle
  localparam int WR_START = 1 + WRITE_LAT - int'(PREFETCH);
  localparam int WR_DONE  = 1 + WRITE_LAT + 3;
  localparam int RD_START = 1 + READ_LAT;

  logic [2:0] state_q;
  logic [3:0] cnt_q;
  logic       in_data;

  assign in_data    = (state_q == S_DATA);
  assign dfi_bank_o = host_addr_i[9:7];

  // Enable windows, all counted from the DFI WRITE/READ cycle
  assign dfi_wstb_o = in_data && host_we_i && (cnt_q == 4'(WR_START - 1));
  assign dfi_wren_o = in_data && host_we_i &&
                      (cnt_q >= 4'(WR_START)) && (cnt_q < 4'(WR_START + 4));
  assign dfi_rden_o = in_data && !host_we_i &&
                      (cnt_q >= 4'(RD_START)) && (cnt_q < 4'(RD_START + 4));
  assign beat_sel_o = cnt_q[1:0] - 2'(WR_START);

  always_comb begin
    dfi_cmd_o.code = CMD_NOP;
    dfi_addr_o     = '0;
    case (state_q)
      S_IDLE: dfi_cmd_o.code = CMD_DESELECT;
      S_ACT: begin
        dfi_cmd_o.code = CMD_ACTIVATE;
        dfi_addr_o     = ADDR_BITS'(host_addr_i[6:3]);
      end
      S_RW: begin
        dfi_cmd_o.code = host_we_i ? CMD_WRITE : CMD_READ;
        // Burst of eight starts on an eight-aligned column
        dfi_addr_o     = ADDR_BITS'({host_addr_i[2:0], 3'b000});
      end
      // A10 stays low, so only the open bank closes
      S_PRE: dfi_cmd_o.code = CMD_PRECHARGE;
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q     <= S_IDLE;
      cnt_q       <= '0;
      host_ack_o  <= 1'b0;
      dfi_cke_o   <= 1'b0;
      dfi_rst_n_o <= 1'b0;
    end else begin
      dfi_cke_o   <= 1'b1;
      dfi_rst_n_o <= 1'b1;
      case (state_q)
        S_IDLE: begin
          if (host_req_i && !host_ack_o && dfi_cke_o) begin
            state_q <= S_ACT;
          end
        end
        S_ACT: begin
          state_q <= S_RCD;
          cnt_q   <= 4'd1;
        end
        S_RCD: begin
          if (cnt_q == 4'(T_RCD - 1)) begin
            state_q <= S_RW;
          end else begin
            cnt_q <= cnt_q + 4'd1;
          end
        end
        S_RW: begin
          state_q <= S_DATA;
          cnt_q   <= 4'd1;
        end
        S_DATA: begin
          if (cnt_q != 4'hf) begin
            cnt_q <= cnt_q + 4'd1;
          end
          // Writes end with the last beat at the pins, reads on the last beat back
          if (host_we_i ? (cnt_q == 4'(WR_DONE)) : (rd_valid_i && rd_last_i)) begin
            state_q <= S_PRE;
          end
        end
        S_PRE: begin
          state_q <= S_RP;
          cnt_q   <= 4'd1;
        end
        S_RP: begin
          if (cnt_q == 4'(T_RP - 1)) begin
            state_q    <= S_ACK;
            host_ack_o <= 1'b1;
          end else begin
            cnt_q <= cnt_q + 4'd1;
          end
        end
        S_ACK: begin
          if (!host_req_i) begin
            state_q    <= S_IDLE;
            host_ack_o <= 1'b0;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Four-phase rule: req may only drop once the access has been acknowledged
  a_req_held: assert property (
    @(posedge clock) disable iff (reset) $fell(host_req_i) |-> host_ack_o
  );

endmodule

`default_nettype wire

//--- verilog/ddr3_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module ddr3_ctrl_top #(
  parameter int DQ_WIDTH = ddr3_pkg::DQ_WIDTH,
  parameter bit PREFETCH = 1'b0
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                host_req_i,
  input  logic                                host_we_i,
  input  logic [ddr3_pkg::HOST_ADDR_BITS-1:0] host_addr_i,
  input  logic [ddr3_pkg::WORD_WIDTH-1:0]     host_wdata_i,
  input  logic [ddr3_pkg::WORD_WIDTH/8-1:0]   host_wmask_i,
  output logic                                host_ack_o,
  output logic [ddr3_pkg::WORD_WIDTH-1:0]     host_rdata_o,
  output logic                                ddr_ck_p_o,
  output logic                                ddr_ck_n_o,
  output logic                                ddr_cke_o,
  output logic                                ddr_rst_n_o,
  output logic                                ddr_cs_n_o,
  output logic                                ddr_ras_n_o,
  output logic                                ddr_cas_n_o,
  output logic                                ddr_we_n_o,
  output logic [ddr3_pkg::BANK_BITS-1:0]      ddr_ba_o,
  output logic [ddr3_pkg::ADDR_BITS-1:0]      ddr_a_o,
  output logic [DQ_WIDTH/8-1:0]               ddr_dm_o,
  inout  wire  [DQ_WIDTH/8-1:0]               ddr_dqs_p_io,
  inout  wire  [DQ_WIDTH/8-1:0]               ddr_dqs_n_io,
  inout  wire  [DQ_WIDTH-1:0]                 ddr_dq_io
);

  import ddr3_pkg::*;

  ddr3_cmd_u               dfi_cmd;
  logic [BANK_BITS-1:0]    dfi_bank;
  logic [ADDR_BITS-1:0]    dfi_addr;
  logic                    dfi_cke;
  logic                    dfi_rst_n;
  logic                    dfi_wstb;
  logic                    dfi_wren;
  logic                    dfi_rden;
  logic [1:0]              beat_sel;
  logic [2*DQ_WIDTH-1:0]   beat_data;
  logic [DQ_WIDTH/4-1:0]   beat_mask;
  logic [2*DQ_WIDTH-1:0]   dfi_rdata;
  logic                    rd_valid;
  logic                    rd_last;

  ddr3_cmd_seq #(.PREFETCH(PREFETCH)) u_cmd_seq (
    .clock       (clock),
    .reset       (reset),
    .host_req_i  (host_req_i),
    .host_we_i   (host_we_i),
    .host_addr_i (host_addr_i),
    .host_ack_o  (host_ack_o),
    .dfi_cmd_o   (dfi_cmd),
    .dfi_bank_o  (dfi_bank),
    .dfi_addr_o  (dfi_addr),
    .dfi_cke_o   (dfi_cke),
    .dfi_rst_n_o (dfi_rst_n),
    .dfi_wstb_o  (dfi_wstb),
    .dfi_wren_o  (dfi_wren),
    .dfi_rden_o  (dfi_rden),
    .beat_sel_o  (beat_sel),
    .rd_valid_i  (rd_valid),
    .rd_last_i   (rd_last)
  );

  ddr3_wr_fmt #(.PREFETCH(PREFETCH)) u_wr_fmt (
    .clock        (clock),
    .reset        (reset),
    .host_wdata_i (host_wdata_i),
    .host_wmask_i (host_wmask_i),
    .beat_sel_i   (beat_sel),
    .beat_data_o  (beat_data),
    .beat_mask_o  (beat_mask)
  );

  ddr3_phy #(.DQ_WIDTH(DQ_WIDTH)) u_phy (
    .clock        (clock),
    .reset        (reset),
    .dfi_cmd_i    (dfi_cmd),
    .dfi_bank_i   (dfi_bank),
    .dfi_addr_i   (dfi_addr),
    .dfi_cke_i    (dfi_cke),
    .dfi_rst_n_i  (dfi_rst_n),
    .dfi_wstb_i   (dfi_wstb),
    .dfi_wren_i   (dfi_wren),
    .beat_data_i  (beat_data),
    .beat_mask_i  (beat_mask),
    .dfi_rdata_o  (dfi_rdata),
    .ddr_ck_p_o   (ddr_ck_p_o),
    .ddr_ck_n_o   (ddr_ck_n_o),
    .ddr_cke_o    (ddr_cke_o),
    .ddr_rst_n_o  (ddr_rst_n_o),
    .ddr_cs_n_o   (ddr_cs_n_o),
    .ddr_ras_n_o  (ddr_ras_n_o),
    .ddr_cas_n_o  (ddr_cas_n_o),
    .ddr_we_n_o   (ddr_we_n_o),
    .ddr_ba_o     (ddr_ba_o),
    .ddr_a_o      (ddr_a_o),
    .ddr_dm_o     (ddr_dm_o),
    .ddr_dqs_p_io (ddr_dqs_p_io),
    .ddr_dqs_n_io (ddr_dqs_n_io),
    .ddr_dq_io    (ddr_dq_io)
  );

  ddr3_rd_gather u_rd_gather (
    .clock        (clock),
    .reset        (reset),
    .dfi_rden_i   (dfi_rden),
    .dfi_rdata_i  (dfi_rdata),
    .rd_valid_o   (rd_valid),
    .rd_last_o    (rd_last),
    .host_rdata_o (host_rdata_o)
  );

endmodule

`default_nettype wire

//--- verilog/ddr3_dq_lane.sv
`timescale 1ns/100ps
`default_nettype none

module ddr3_dq_lane (
  input  logic clock,
  input  logic reset,
  input  logic oe_i,
  input  logic d_rise_i,
  input  logic d_fall_i,
  output logic q_rise_o,
  output logic q_fall_o,
  inout  wire  dq_io
);

  logic rise_cap;

  // Rising-edge data in the high half of the clock, falling-edge data in the low half
  assign dq_io = oe_i ? (clock ? d_rise_i : d_fall_i) : 1'bz;

  // Mid-high sample holds the rising-edge transfer
  always_ff @(negedge clock) begin
    rise_cap <= dq_io;
  end

  // Re-time both halves of the cycle onto the rising edge
  always_ff @(posedge clock) begin
    if (reset) begin
      q_rise_o <= 1'b0;
      q_fall_o <= 1'b0;
    end else begin
      q_rise_o <= rise_cap;
      q_fall_o <= dq_io;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ddr3_phy.sv
`timescale 1ns/100ps
`default_nettype none

module ddr3_phy #(
  parameter int DQ_WIDTH = ddr3_pkg::DQ_WIDTH
) (
  input  logic                            clock,
  input  logic                            reset,
  input  ddr3_pkg::ddr3_cmd_u             dfi_cmd_i,
  input  logic [ddr3_pkg::BANK_BITS-1:0]  dfi_bank_i,
  input  logic [ddr3_pkg::ADDR_BITS-1:0]  dfi_addr_i,
  input  logic                            dfi_cke_i,
  input  logic                            dfi_rst_n_i,
  input  logic                            dfi_wstb_i,
  input  logic                            dfi_wren_i,
  input  logic [2*DQ_WIDTH-1:0]           beat_data_i,
  input  logic [DQ_WIDTH/4-1:0]           beat_mask_i,
  output logic [2*DQ_WIDTH-1:0]           dfi_rdata_o,
  output logic                            ddr_ck_p_o,
  output logic                            ddr_ck_n_o,
  output logic                            ddr_cke_o,
  output logic                            ddr_rst_n_o,
  output logic                            ddr_cs_n_o,
  output logic                            ddr_ras_n_o,
  output logic                            ddr_cas_n_o,
  output logic                            ddr_we_n_o,
  output logic [ddr3_pkg::BANK_BITS-1:0]  ddr_ba_o,
  output logic [ddr3_pkg::ADDR_BITS-1:0]  ddr_a_o,
  output logic [DQ_WIDTH/8-1:0]           ddr_dm_o,
  inout  wire  [DQ_WIDTH/8-1:0]           ddr_dqs_p_io,
  inout  wire  [DQ_WIDTH/8-1:0]           ddr_dqs_n_io,
  inout  wire  [DQ_WIDTH-1:0]             ddr_dq_io
);

  import ddr3_pkg::*;

  localparam int NB = DQ_WIDTH / 8;

  ddr3_cmd_u cmd_q;
  logic      wren_q;
  logic      rd_open_q;
  logic      wr_oe;
  logic      dqs_oe;

  // Command pins idle deselected, with CKE and reset held low
  always_ff @(posedge clock) begin
    if (reset) begin
      cmd_q.code  <= CMD_DESELECT;
      ddr_cke_o   <= 1'b0;
      ddr_rst_n_o <= 1'b0;
      ddr_ba_o    <= '0;
      ddr_a_o     <= '0;
      wren_q      <= 1'b0;
    end else begin
      cmd_q       <= dfi_cmd_i;
      ddr_cke_o   <= dfi_cke_i;
      ddr_rst_n_o <= dfi_rst_n_i;
      ddr_ba_o    <= dfi_bank_i;
      ddr_a_o     <= dfi_addr_i;
      wren_q      <= dfi_wren_i;
    end
  end

  // A read burst stays open on the pins until its precharge
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_open_q <= 1'b0;
    end else if (cmd_q.code == CMD_READ) begin
      rd_open_q <= 1'b1;
    end else if (cmd_q.code == CMD_PRECHARGE) begin
      rd_open_q <= 1'b0;
    end
  end

  assign ddr_cs_n_o  = cmd_q.pins.cs_n;
  assign ddr_ras_n_o = cmd_q.pins.ras_n;
  assign ddr_cas_n_o = cmd_q.pins.cas_n;
  assign ddr_we_n_o  = cmd_q.pins.we_n;

  assign ddr_ck_p_o = clock;
  assign ddr_ck_n_o = ~clock;

  // One extra cycle of drive covers the last beat with or without prefetch
  assign wr_oe  = dfi_wren_i | wren_q;
  assign dqs_oe = dfi_wstb_i | wr_oe;

  assign ddr_dqs_p_io = dqs_oe ? {NB{clock}} : {NB{1'bz}};
  assign ddr_dqs_n_io = dqs_oe ? {NB{~clock}} : {NB{1'bz}};

  // DM high masks the byte, so the byte enables flip back here
  assign ddr_dm_o = clock ? ~beat_mask_i[NB-1:0] : ~beat_mask_i[2*NB-1:NB];

  generate
    for (genvar i = 0; i < DQ_WIDTH; i++) begin : g_dq_lane
      ddr3_dq_lane u_dq_lane (
        .clock    (clock),
        .reset    (reset),
        .oe_i     (wr_oe),
        .d_rise_i (beat_data_i[i]),
        .d_fall_i (beat_data_i[DQ_WIDTH + i]),
        .q_rise_o (dfi_rdata_o[i]),
        .q_fall_o (dfi_rdata_o[DQ_WIDTH + i]),
        .dq_io    (ddr_dq_io[i])
      );
    end
  endgenerate

  // Sequencer must never drive write data into a read burst
  a_no_wren_on_read: assert property (
    @(posedge clock) disable iff (reset)
    ((cmd_q.code == CMD_READ) || rd_open_q) |-> !dfi_wren_i
  );

endmodule

`default_nettype wire

//--- verilog/ddr3_pkg.sv
`default_nettype none

package ddr3_pkg;

  // One DFI beat carries two DQ transfers, one host word four beats
  localparam int DQ_WIDTH   = 16;
  localparam int BEAT_WIDTH = 2 * DQ_WIDTH;
  localparam int WORD_WIDTH = 4 * BEAT_WIDTH;

  localparam int BANK_BITS = 3;
  localparam int ADDR_BITS = 14;

  // Host word address is {bank[2:0], row[3:0], column block[2:0]}
  localparam int HOST_ADDR_BITS = 10;

  // Latencies in clock cycles, counted at the DDR3 pins
  localparam int WRITE_LAT = 5;
  localparam int READ_LAT  = 6;
  localparam int T_RCD     = 3;
  localparam int T_RP      = 3;

  // Command codes equal the pin levels {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_NOP       = 4'b0111,
    CMD_ACTIVATE  = 4'b0011,
    CMD_READ      = 4'b0101,
    CMD_WRITE     = 4'b0100,
    CMD_PRECHARGE = 4'b0010,
    CMD_DESELECT  = 4'b1111
  } ddr3_cmd_e;

  typedef union packed {
    ddr3_cmd_e code;
    struct packed {
      logic cs_n;
      logic ras_n;
      logic cas_n;
      logic we_n;
    } pins;
  } ddr3_cmd_u;

endpackage

`default_nettype wire

//--- verilog/ddr3_rd_gather.sv
`timescale 1ns/100ps
`default_nettype none

module ddr3_rd_gather (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             dfi_rden_i,
  input  logic [ddr3_pkg::BEAT_WIDTH-1:0]  dfi_rdata_i,
  output logic                             rd_valid_o,
  output logic                             rd_last_o,
  output logic [ddr3_pkg::WORD_WIDTH-1:0]  host_rdata_o
);

  import ddr3_pkg::*;

  logic                  rden_q;
  logic [1:0]            beat_idx_q;
  logic [BEAT_WIDTH-1:0] rdata_q;

  // Two-stage delay line: one for the lane capture, one for rdata_q
  always_ff @(posedge clock) begin
    if (reset) begin
      rden_q     <= 1'b0;
      rd_valid_o <= 1'b0;
      beat_idx_q <= 2'd0;
    end else begin
      rden_q     <= dfi_rden_i;
      rd_valid_o <= rden_q;
      if (rd_valid_o) begin
        beat_idx_q <= beat_idx_q + 2'd1;
      end
    end
  end

  assign rd_last_o = rd_valid_o && (beat_idx_q == 2'd3);

  // Word is held until the next burst overwrites it
  always_ff @(posedge clock) begin
    rdata_q <= dfi_rdata_i;
    if (rd_valid_o) begin
      host_rdata_o[beat_idx_q * BEAT_WIDTH +: BEAT_WIDTH] <= rdata_q;
    end
  end

  // Every burst is four back-to-back beats, the fourth one flagged last
  a_burst_of_four: assert property (
    @(posedge clock) disable iff (reset)
    $rose(rd_valid_o) |-> rd_valid_o [*3] ##1 (rd_valid_o && rd_last_o) ##1 !rd_valid_o
  );

endmodule

`default_nettype wire

//--- verilog/ddr3_wr_fmt.sv
`timescale 1ns/100ps
`default_nettype none

module ddr3_wr_fmt #(
  parameter bit PREFETCH = 1'b0
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [ddr3_pkg::WORD_WIDTH-1:0]     host_wdata_i,
  input  logic [ddr3_pkg::WORD_WIDTH/8-1:0]   host_wmask_i,
  input  logic [1:0]                          beat_sel_i,
  output logic [ddr3_pkg::BEAT_WIDTH-1:0]     beat_data_o,
  output logic [ddr3_pkg::BEAT_WIDTH/8-1:0]   beat_mask_o
);

  import ddr3_pkg::*;

  localparam int BEAT_BYTES = BEAT_WIDTH / 8;

  logic [BEAT_WIDTH-1:0] sel_data;
  logic [BEAT_BYTES-1:0] sel_en;

  // Beat n is word bits [32n+31:32n], its low half goes out on the rising edge
  assign sel_data = host_wdata_i[beat_sel_i * BEAT_WIDTH +: BEAT_WIDTH];

  // Host mask blocks a byte, so invert to get per-byte write enables
  assign sel_en = ~host_wmask_i[beat_sel_i * BEAT_BYTES +: BEAT_BYTES];

  generate
    if (PREFETCH) begin : g_prefetch
      logic [BEAT_WIDTH-1:0] data_q;
      logic [BEAT_BYTES-1:0] en_q;

      // Extra register stage in front of the pins
      always_ff @(posedge clock) begin
        data_q <= sel_data;
        if (reset) begin
          en_q <= '0;
        end else begin
          en_q <= sel_en;
        end
      end

      assign beat_data_o = data_q;
      assign beat_mask_o = en_q;
    end else begin : g_direct
      assign beat_data_o = sel_data;
      assign beat_mask_o = sel_en;
    end
  endgenerate

endmodule

`default_nettype wire
